/* Bender.yml */
package:
  name: pipeline_core

sources:
  - files:
      - design/types.sv
      - design/PipelineBus.sv
      - design/StageIF.sv
      - design/InstDecoder.sv
      - design/RegisterFile.sv
      - design/StageID.sv
      - design/StageEX.sv
      - design/StageMEM.sv
      - design/PipelineCore.sv
  - target: test
    files:
      - testbench/ClockGen.sv
      - testbench/PipelineCoreTb.sv

/* PipelineCore.f */
design/types.sv
design/PipelineBus.sv
design/StageIF.sv
design/InstDecoder.sv
design/RegisterFile.sv
design/StageID.sv
design/StageEX.sv
design/StageMEM.sv
design/PipelineCore.sv
testbench/ClockGen.sv
testbench/PipelineCoreTb.sv

/* design/InstDecoder.sv */
module InstDecoder (
    input  logic [31:0]                  i_Inst,
    input  logic                         i_IsEQ,         // rs1 == rs2
    input  logic                         i_IsLT,         // rs1 < rs2, signed
    output logic [types::REG_WIDTH-1:0]  o_Rs1,
    output logic [types::REG_WIDTH-1:0]  o_Rs2,
    output logic [types::REG_WIDTH-1:0]  o_Rd,
    output logic [types::DATA_WIDTH-1:0] o_Imm,
    output logic                         o_RegWrEnable,
    output logic                         o_MemWrEnable,
    output logic                         o_OperandASel,
    output logic                         o_OperandBSel,
    output types::WbSel                  o_WbSel,
    output types::AluOp                  o_AluControl,
    output types::PcSel                  o_PcSel);

    import types::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = i_Inst[6:0];
    assign funct3 = i_Inst[14:12];
    assign funct7 = i_Inst[31:25];

    assign o_Rs1 = i_Inst[19:15];
    assign o_Rs2 = i_Inst[24:20];
    assign o_Rd  = i_Inst[11:7];

    // ----------------------------------------
    // Immediate by instruction format
    // ----------------------------------------
    always_comb begin
        case (opcode)
            OP_STORE:  o_Imm = {{20{i_Inst[31]}}, i_Inst[31:25], i_Inst[11:7]};
            OP_BRANCH: o_Imm = {{19{i_Inst[31]}}, i_Inst[31], i_Inst[7], i_Inst[30:25],
                                i_Inst[11:8], 1'b0};
            OP_LUI:    o_Imm = {i_Inst[31:12], 12'd0};
            OP_JAL:    o_Imm = {{11{i_Inst[31]}}, i_Inst[31], i_Inst[19:12], i_Inst[20],
                                i_Inst[30:21], 1'b0};
            default:   o_Imm = {{20{i_Inst[31]}}, i_Inst[31:20]};  // I format, ADDI and LW
        endcase
    end

    // ----------------------------------------
    // Datapath control and next PC
    // ----------------------------------------
    always_comb begin
        o_RegWrEnable = 1'b0;
        o_MemWrEnable = 1'b0;
        o_OperandASel = 1'b0;
        o_OperandBSel = 1'b0;
        o_WbSel       = WB_ALU;
        o_AluControl  = ALU_ADD;
        o_PcSel       = PC_PLUS4;
        case (opcode)
            OP_R: begin
                o_RegWrEnable = 1'b1;
                case (funct3)
                    3'b000:  o_AluControl = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b111:  o_AluControl = ALU_AND;
                    3'b110:  o_AluControl = ALU_OR;
                    3'b100:  o_AluControl = ALU_XOR;
                    3'b010:  o_AluControl = ALU_SLT;
                    default: o_RegWrEnable = 1'b0;          // Unsupported R-type
                endcase
            end
            OP_I: begin
                o_RegWrEnable = (funct3 == 3'b000);         // ADDI only
                o_OperandBSel = 1'b1;
            end
            OP_LUI: begin
                o_RegWrEnable = 1'b1;
                o_OperandBSel = 1'b1;
                o_AluControl  = ALU_PASSB;
            end
            OP_LOAD: begin
                o_RegWrEnable = 1'b1;
                o_OperandBSel = 1'b1;                       // Base plus offset
                o_WbSel       = WB_MEM;
            end
            OP_STORE: begin
                o_MemWrEnable = 1'b1;
                o_OperandBSel = 1'b1;
            end
            OP_BRANCH: begin
                case (funct3)
                    3'b000:  o_PcSel = i_IsEQ ? PC_BRANCH : PC_PLUS4;  // BEQ
                    3'b001:  o_PcSel = i_IsEQ ? PC_PLUS4 : PC_BRANCH;  // BNE
                    3'b100:  o_PcSel = i_IsLT ? PC_BRANCH : PC_PLUS4;  // BLT
                    default: o_PcSel = PC_PLUS4;
                endcase
            end
            OP_JAL: begin
                o_RegWrEnable = 1'b1;
                o_OperandASel = 1'b1;                       // ALU forms the jump target
                o_OperandBSel = 1'b1;
                o_WbSel       = WB_PC4;
                o_PcSel       = PC_JUMP;
            end
            default: ;                                      // Unknown opcodes write nothing
        endcase
    end

endmodule

/* design/PipelineBus.sv */
interface IfIdBus;
    logic                       Valid;              // Live instruction in ID
    logic [types::PC_WIDTH-1:0] PC;                 // Its fetch address
    logic [31:0]                Inst;               // Raw instruction word

    modport src (output Valid, PC, Inst);
    modport dst (input  Valid, PC, Inst);
endinterface

interface IdExBus;
    logic                         Valid;
    logic [types::PC_WIDTH-1:0]   PC;
    logic [types::DATA_WIDTH-1:0] DataA;            // Forwarded rs1
    logic [types::DATA_WIDTH-1:0] DataB;            // Forwarded rs2
    logic [types::DATA_WIDTH-1:0] Imm;
    logic [types::REG_WIDTH-1:0]  RegWrAddr;
    logic                         RegWrEnable;
    types::WbSel                  WbSel;            // WB_MEM marks a load
    logic                         MemWrEnable;
    logic                         OperandASel;      // 1 picks PC
    logic                         OperandBSel;      // 1 picks Imm
    types::AluOp                  AluControl;

    modport src (output Valid, PC, DataA, DataB, Imm, RegWrAddr, RegWrEnable, WbSel,
                 MemWrEnable, OperandASel, OperandBSel, AluControl);
    modport dst (input  Valid, PC, DataA, DataB, Imm, RegWrAddr, RegWrEnable, WbSel,
                 MemWrEnable, OperandASel, OperandBSel, AluControl);
endinterface

interface ExMemBus;
    logic                         Valid;
    logic [types::PC_WIDTH-1:0]   PC;               // Kept for the link value
    logic [types::DATA_WIDTH-1:0] AluResult;        // Also the RAM address
    logic [types::DATA_WIDTH-1:0] StoreData;
    logic [types::REG_WIDTH-1:0]  RegWrAddr;
    logic                         RegWrEnable;
    types::WbSel                  WbSel;
    logic                         MemWrEnable;

    modport src (output Valid, PC, AluResult, StoreData, RegWrAddr, RegWrEnable, WbSel,
                 MemWrEnable);
    modport dst (input  Valid, PC, AluResult, StoreData, RegWrAddr, RegWrEnable, WbSel,
                 MemWrEnable);
endinterface

interface MemWbBus;
    logic                         Valid;
    logic [types::REG_WIDTH-1:0]  RegWrAddr;
    logic                         RegWrEnable;
    logic [types::DATA_WIDTH-1:0] RegWrData;        // Final write-back value

    modport src (output Valid, RegWrAddr, RegWrEnable, RegWrData);
    modport dst (input  Valid, RegWrAddr, RegWrEnable, RegWrData);
endinterface

/* design/PipelineCore.sv */
module PipelineCore (
    input  logic                         i_Clock,
    input  logic                         i_reset,
    output logic [types::PC_WIDTH-1:0]   o_InstAddr,     // Instruction ROM
    input  logic [31:0]                  i_Inst,
    output logic [types::DATA_WIDTH-1:0] o_MemAddr,      // Data RAM
    output logic [types::DATA_WIDTH-1:0] o_MemWrData,
    output logic                         o_MemWrEnable,
    input  logic [types::DATA_WIDTH-1:0] i_MemRdData);

    import types::*;

    IfIdBus  ifIdBus ();
    IdExBus  idExBus ();
    ExMemBus exMemBus ();
    MemWbBus memWbBus ();

    logic                  stall, redirect;
    logic [PC_WIDTH-1:0]   pcNext;
    logic [DATA_WIDTH-1:0] exAluResult, memRegWrData;

    StageIF if0 (
        .i_Clock    (i_Clock),
        .i_reset    (i_reset),
        .i_Stall    (stall),
        .i_Redirect (redirect),
        .i_PcNext   (pcNext),
        .o_InstAddr (o_InstAddr),
        .i_Inst     (i_Inst),
        .o_IfId     (ifIdBus));

    StageID id0 (
        .i_Clock        (i_Clock),
        .i_reset        (i_reset),
        .i_IfId         (ifIdBus),
        .o_IdEx         (idExBus),
        .i_IdEx         (idExBus),
        .i_ExMem        (exMemBus),
        .i_MemWb        (memWbBus),
        .i_ExAluResult  (exAluResult),
        .i_MemRegWrData (memRegWrData),
        .o_Stall        (stall),
        .o_Redirect     (redirect),
        .o_PcNext       (pcNext));

    StageEX ex0 (
        .i_Clock     (i_Clock),
        .i_reset     (i_reset),
        .i_IdEx      (idExBus),
        .o_ExMem     (exMemBus),
        .o_AluResult (exAluResult));

    StageMEM mem0 (
        .i_Clock       (i_Clock),
        .i_reset       (i_reset),
        .i_ExMem       (exMemBus),
        .o_MemAddr     (o_MemAddr),
        .o_MemWrData   (o_MemWrData),
        .o_MemWrEnable (o_MemWrEnable),
        .i_MemRdData   (i_MemRdData),
        .o_RegWrData   (memRegWrData),
        .o_MemWb       (memWbBus));

endmodule

/* design/RegisterFile.sv */
module RegisterFile (
    input  logic                         i_Clock,
    input  logic                         i_reset,
    input  logic                         i_WrEnable,
    input  logic [types::REG_WIDTH-1:0]  i_WrAddr,
    input  logic [types::DATA_WIDTH-1:0] i_WrData,
    input  logic [types::REG_WIDTH-1:0]  i_RdAddrA,
    input  logic [types::REG_WIDTH-1:0]  i_RdAddrB,
    output logic [types::DATA_WIDTH-1:0] o_RdDataA,
    output logic [types::DATA_WIDTH-1:0] o_RdDataB);

    import types::*;

    logic [DATA_WIDTH-1:0] regs [2**REG_WIDTH];

    always_ff @(posedge i_Clock) begin
        if (i_reset) begin
            for (int i = 0; i < 2**REG_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (i_WrEnable && i_WrAddr != '0) begin
            regs[i_WrAddr] <= i_WrData;
        end
    end

    // x0 reads zero, a same-cycle write is passed through
    assign o_RdDataA = (i_RdAddrA == '0) ? '0 :
                       (i_WrEnable && i_WrAddr == i_RdAddrA) ? i_WrData : regs[i_RdAddrA];
    assign o_RdDataB = (i_RdAddrB == '0) ? '0 :
                       (i_WrEnable && i_WrAddr == i_RdAddrB) ? i_WrData : regs[i_RdAddrB];

endmodule

/* design/StageEX.sv */
module StageEX (
    input  logic                         i_Clock,
    input  logic                         i_reset,
    IdExBus.dst                          i_IdEx,
    ExMemBus.src                         o_ExMem,
    output logic [types::DATA_WIDTH-1:0] o_AluResult); // To ID forwarding

    import types::*;

    logic [DATA_WIDTH-1:0] opA, opB, result;

    assign opA = i_IdEx.OperandASel ? i_IdEx.PC : i_IdEx.DataA;
    assign opB = i_IdEx.OperandBSel ? i_IdEx.Imm : i_IdEx.DataB;

    always_comb begin
        case (i_IdEx.AluControl)
            ALU_SUB:   result = opA - opB;
            ALU_AND:   result = opA & opB;
            ALU_OR:    result = opA | opB;
            ALU_XOR:   result = opA ^ opB;
            ALU_SLT:   result = {{(DATA_WIDTH-1){1'b0}}, $signed(opA) < $signed(opB)};
            ALU_PASSB: result = opB;                // LUI
            default:   result = opA + opB;          // ADD, address calc
        endcase
    end

    assign o_AluResult = result;

    // EX/MEM register
    always_ff @(posedge i_Clock) begin
        if (i_reset) begin
            o_ExMem.Valid       <= 1'b0;
            o_ExMem.RegWrEnable <= 1'b0;
            o_ExMem.MemWrEnable <= 1'b0;
        end else begin
            o_ExMem.Valid       <= i_IdEx.Valid;
            o_ExMem.RegWrEnable <= i_IdEx.RegWrEnable;
            o_ExMem.MemWrEnable <= i_IdEx.MemWrEnable;
        end
    end

    always_ff @(posedge i_Clock) begin
        o_ExMem.PC        <= i_IdEx.PC;
        o_ExMem.AluResult <= result;
        o_ExMem.StoreData <= i_IdEx.DataB;          // rs2 of a store
        o_ExMem.RegWrAddr <= i_IdEx.RegWrAddr;
        o_ExMem.WbSel     <= i_IdEx.WbSel;
    end

endmodule

/* design/StageID.sv */
module StageID (
    input  logic                         i_Clock,
    input  logic                         i_reset,
    IfIdBus.dst                          i_IfId,
    IdExBus.src                          o_IdEx,
    IdExBus.dst                          i_IdEx,         // Instruction now in EX
    ExMemBus.dst                         i_ExMem,        // Instruction now in MEM
    MemWbBus.dst                         i_MemWb,        // Instruction now in WB
    input  logic [types::DATA_WIDTH-1:0] i_ExAluResult,  // Combinational EX result
    input  logic [types::DATA_WIDTH-1:0] i_MemRegWrData, // MEM write-back value
    output logic                         o_Stall,
    output logic                         o_Redirect,
    output logic [types::PC_WIDTH-1:0]   o_PcNext);

    import types::*;

    logic [REG_WIDTH-1:0]  rs1, rs2, rd;
    logic [DATA_WIDTH-1:0] imm;
    logic                  regWrEnable, memWrEnable;
    logic                  operandASel, operandBSel;
    WbSel                  wbSel;
    AluOp                  aluControl;
    PcSel                  pcSel;
    logic                  isEq, isLt;

    InstDecoder dec0 (
        .i_Inst        (i_IfId.Inst),
        .i_IsEQ        (isEq),
        .i_IsLT        (isLt),
        .o_Rs1         (rs1),
        .o_Rs2         (rs2),
        .o_Rd          (rd),
        .o_Imm         (imm),
        .o_RegWrEnable (regWrEnable),
        .o_MemWrEnable (memWrEnable),
        .o_OperandASel (operandASel),
        .o_OperandBSel (operandBSel),
        .o_WbSel       (wbSel),
        .o_AluControl  (aluControl),
        .o_PcSel       (pcSel));

    logic [DATA_WIDTH-1:0] fileDataA, fileDataB;

    RegisterFile regs0 (
        .i_Clock    (i_Clock),
        .i_reset    (i_reset),
        .i_WrEnable (i_MemWb.RegWrEnable),
        .i_WrAddr   (i_MemWb.RegWrAddr),
        .i_WrData   (i_MemWb.RegWrData),
        .i_RdAddrA  (rs1),
        .i_RdAddrB  (rs2),
        .o_RdDataA  (fileDataA),
        .o_RdDataB  (fileDataB));

    // ----------------------------------------
    // Forwarding, newest producer first
    // ----------------------------------------
    logic [DATA_WIDTH-1:0] exData, dataA, dataB;
    FwdSel                 fwdA, fwdB;

    // JAL in EX forwards its link address, not the ALU sum
    assign exData = (i_IdEx.WbSel == WB_PC4) ? i_IdEx.PC + PC_WIDTH'(4) : i_ExAluResult;

    function automatic FwdSel pickFwd(input logic [REG_WIDTH-1:0] rs);
        if (rs == '0)
            return FWD_FILE;                        // x0 is never forwarded
        if (i_IdEx.Valid && i_IdEx.RegWrEnable && i_IdEx.RegWrAddr == rs)
            return FWD_EX;
        if (i_ExMem.Valid && i_ExMem.RegWrEnable && i_ExMem.RegWrAddr == rs)
            return FWD_MEM;
        if (i_MemWb.Valid && i_MemWb.RegWrEnable && i_MemWb.RegWrAddr == rs)
            return FWD_WB;
        return FWD_FILE;
    endfunction

    always_comb begin
        fwdA = pickFwd(rs1);
        fwdB = pickFwd(rs2);
        case (fwdA)
            FWD_EX:  dataA = exData;
            FWD_MEM: dataA = i_MemRegWrData;
            FWD_WB:  dataA = i_MemWb.RegWrData;
            default: dataA = fileDataA;
        endcase
        case (fwdB)
            FWD_EX:  dataB = exData;
            FWD_MEM: dataB = i_MemRegWrData;
            FWD_WB:  dataB = i_MemWb.RegWrData;
            default: dataB = fileDataB;
        endcase
    end

    // ----------------------------------------
    // Branch compare, hazard and next PC
    // ----------------------------------------
    logic loadUse;

    assign isEq = (dataA == dataB);
    assign isLt = ($signed(dataA) < $signed(dataB));

    assign loadUse = i_IfId.Valid && i_IdEx.Valid && i_IdEx.RegWrEnable &&
                     i_IdEx.WbSel == WB_MEM && i_IdEx.RegWrAddr != '0 &&
                     (i_IdEx.RegWrAddr == rs1 || i_IdEx.RegWrAddr == rs2);

    assign o_Stall    = loadUse;
    assign o_Redirect = i_IfId.Valid && !loadUse && pcSel != PC_PLUS4; // Wait for operands
    assign o_PcNext   = (pcSel == PC_PLUS4) ? i_IfId.PC + PC_WIDTH'(4) : i_IfId.PC + imm;

    // ID/EX register
    always_ff @(posedge i_Clock) begin
        if (i_reset || loadUse) begin               // Bubble on a stall
            o_IdEx.Valid       <= 1'b0;
            o_IdEx.RegWrEnable <= 1'b0;
            o_IdEx.MemWrEnable <= 1'b0;
        end else begin
            o_IdEx.Valid       <= i_IfId.Valid;
            o_IdEx.RegWrEnable <= i_IfId.Valid && regWrEnable;
            o_IdEx.MemWrEnable <= i_IfId.Valid && memWrEnable;
        end
    end

    always_ff @(posedge i_Clock) begin
        o_IdEx.PC          <= i_IfId.PC;
        o_IdEx.DataA       <= dataA;
        o_IdEx.DataB       <= dataB;
        o_IdEx.Imm         <= imm;
        o_IdEx.RegWrAddr   <= rd;
        o_IdEx.WbSel       <= wbSel;
        o_IdEx.OperandASel <= operandASel;
        o_IdEx.OperandBSel <= operandBSel;
        o_IdEx.AluControl  <= aluControl;
    end

endmodule

/* design/StageIF.sv */
module StageIF (
    input  logic                       i_Clock,
    input  logic                       i_reset,
    input  logic                       i_Stall,     // Load-use hold
    input  logic                       i_Redirect,  // Taken branch or jump in ID
    input  logic [types::PC_WIDTH-1:0] i_PcNext,    // Redirect target
    output logic [types::PC_WIDTH-1:0] o_InstAddr,  // ROM address
    input  logic [31:0]                i_Inst,      // ROM data, same cycle
    IfIdBus.src                        o_IfId);

    import types::*;

    logic [PC_WIDTH-1:0] pc;

    assign o_InstAddr = pc;

    // PC and IF/ID valid bit
    always_ff @(posedge i_Clock) begin
        if (i_reset) begin
            pc          <= '0;
            o_IfId.Valid <= 1'b0;
        end else if (i_Redirect) begin
            pc          <= i_PcNext;
            o_IfId.Valid <= 1'b0;                   // Squash the wrong-path fetch
        end else if (!i_Stall) begin
            pc          <= pc + PC_WIDTH'(4);
            o_IfId.Valid <= 1'b1;
        end
    end

    always_ff @(posedge i_Clock) begin
        if (!i_Stall) begin                         // Hold the word under a stall
            o_IfId.PC   <= pc;
            o_IfId.Inst <= i_Inst;
        end
    end

endmodule

/* design/StageMEM.sv */
module StageMEM (
    input  logic                         i_Clock,
    input  logic                         i_reset,
    ExMemBus.dst                         i_ExMem,
    output logic [types::DATA_WIDTH-1:0] o_MemAddr,
    output logic [types::DATA_WIDTH-1:0] o_MemWrData,
    output logic                         o_MemWrEnable,
    input  logic [types::DATA_WIDTH-1:0] i_MemRdData,  // Combinational RAM read
    output logic [types::DATA_WIDTH-1:0] o_RegWrData,  // To ID forwarding
    MemWbBus.src                         o_MemWb);

    import types::*;

    logic [DATA_WIDTH-1:0] wbData;

    assign o_MemAddr     = i_ExMem.AluResult;
    assign o_MemWrData   = i_ExMem.StoreData;
    assign o_MemWrEnable = i_ExMem.Valid && i_ExMem.MemWrEnable;

    always_comb begin
        case (i_ExMem.WbSel)
            WB_MEM:  wbData = i_MemRdData;
            WB_PC4:  wbData = i_ExMem.PC + PC_WIDTH'(4);   // Link address
            default: wbData = i_ExMem.AluResult;
        endcase
    end

    assign o_RegWrData = wbData;

    // MEM/WB register
    always_ff @(posedge i_Clock) begin
        if (i_reset) begin
            o_MemWb.Valid       <= 1'b0;
            o_MemWb.RegWrEnable <= 1'b0;
        end else begin
            o_MemWb.Valid       <= i_ExMem.Valid;
            o_MemWb.RegWrEnable <= i_ExMem.RegWrEnable;
        end
    end

    always_ff @(posedge i_Clock) begin
        o_MemWb.RegWrAddr <= i_ExMem.RegWrAddr;
        o_MemWb.RegWrData <= wbData;
    end

endmodule

/* design/types.sv */
package types;

    localparam int DATA_WIDTH = 32;                 // One machine word
    localparam int PC_WIDTH   = 32;                 // Byte address of an instruction
    localparam int REG_WIDTH  = 5;                  // 32 architectural registers

    // ----------------------------------------
    // RV32I major opcodes
    // ----------------------------------------
    localparam logic [6:0] OP_R      = 7'b0110011;  // Register-register ALU
    localparam logic [6:0] OP_I      = 7'b0010011;  // Register-immediate ALU
    localparam logic [6:0] OP_LUI    = 7'b0110111;  // Upper immediate
    localparam logic [6:0] OP_LOAD   = 7'b0000011;  // LW
    localparam logic [6:0] OP_STORE  = 7'b0100011;  // SW
    localparam logic [6:0] OP_BRANCH = 7'b1100011;  // BEQ, BNE, BLT
    localparam logic [6:0] OP_JAL    = 7'b1101111;  // Jump and link

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,                                    // Signed compare
        ALU_PASSB                                   // Operand B straight through, for LUI
    } AluOp;

    // Source of the register write data
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4                                      // Link address
    } WbSel;

    // Source of an ID operand
    typedef enum logic [1:0] {
        FWD_FILE,
        FWD_EX,
        FWD_MEM,
        FWD_WB
    } FwdSel;

    // Next PC source
    typedef enum logic [1:0] {
        PC_PLUS4,
        PC_BRANCH,
        PC_JUMP
    } PcSel;

endpackage

/* testbench/ClockGen.sv */
module ClockGen (
    output logic o_Clock);

    initial o_Clock = 1'b0;                         // Low until the first half period

    always #5 o_Clock = ~o_Clock;                   // 10-unit period

endmodule

/* testbench/PipelineCoreTb.sv */
module PipelineCoreTb;

    localparam int         MAX_CYCLES = 400;        // Reset and about 60 issue slots, five times over
    localparam logic [6:0] OP_IMM     = 7'b0010011;

    logic        clock, reset, memWrEnable;
    logic [31:0] instAddr, inst, memAddr, memWrData, memRdData;
    logic [31:0] rom [64];
    logic [31:0] ram [64];
    logic [31:0] expAddr[$], expData[$];
    string       expName[$];
    logic [11:0] immA, immB;                        // Random ADDI operands
    int          progLen, storeCount, cycle;
    logic        released;

    ClockGen clk0 (.o_Clock(clock));

    PipelineCore dut0 (
        .i_Clock       (clock),
        .i_reset       (reset),
        .o_InstAddr    (instAddr),
        .i_Inst        (inst),
        .o_MemAddr     (memAddr),
        .o_MemWrData   (memWrData),
        .o_MemWrEnable (memWrEnable),
        .i_MemRdData   (memRdData));

    assign inst      = rom[instAddr[7:2]];          // Combinational ROM
    assign memRdData = ram[memAddr[7:2]];           // Combinational RAM read

    // ----------------------------------------
    // Instruction encoders
    // ----------------------------------------
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    // SW rs2, imm(x0)
    function automatic logic [31:0] encS(input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encB(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                         input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encJ(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] word);
        rom[progLen] = word;
        progLen++;
    endtask

    task automatic expectStore(input string name, input logic [31:0] addr, data);
        expName.push_back(name);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected, actual);
        assert (actual === expected)
        else stopRun($sformatf("CHECK FAILED %s: expected %h, actual %h", name, expected, actual));
    endtask

    // ----------------------------------------
    // Program and its expected stores
    // ----------------------------------------
    task automatic loadProgram();
        logic [31:0] x [32];                        // Architectural register values
        logic [31:0] link;
        x[1] = {{20{immA[11]}}, immA};
        x[2] = {{20{immB[11]}}, immB};
        emit(encI(OP_IMM, 3'b000, 5'd1, 5'd0, immA));
        emit(encI(OP_IMM, 3'b000, 5'd2, 5'd0, immB));
        emit(encR(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        x[3] = x[1] + x[2];
        emit(encR(7'h20, 3'b000, 5'd4, 5'd1, 5'd3));   // EX fwd
        x[4] = x[1] - x[3];
        emit(encR(7'h00, 3'b111, 5'd5, 5'd3, 5'd4));   // MEM fwd
        x[5] = x[3] & x[4];
        emit(encR(7'h00, 3'b110, 5'd6, 5'd3, 5'd5));   // WB fwd
        x[6] = x[3] | x[5];
        emit(encR(7'h00, 3'b100, 5'd7, 5'd4, 5'd6));
        x[7] = x[4] ^ x[6];
        emit(encR(7'h00, 3'b010, 5'd8, 5'd7, 5'd5));
        x[8] = ($signed(x[7]) < $signed(x[5])) ? 32'd1 : 32'd0;
        emit(encI(OP_IMM, 3'b000, 5'd9, 5'd8, 12'd5));
        x[9] = x[8] + 32'd5;
        emit({20'h12345, 5'd10, 7'b0110111});          // LUI
        x[10] = 32'h12345000;
        emit(encR(7'h00, 3'b000, 5'd11, 5'd10, 5'd9));
        x[11] = x[10] + x[9];
        for (int r = 3; r <= 11; r++) begin
            emit(encS(5'(r), 12'((r - 3) * 4)));
            expectStore($sformatf("alu x%0d", r), 32'((r - 3) * 4), x[r]);
        end
        emit(encI(7'b0000011, 3'b010, 5'd13, 5'd0, 12'd32));  // LW x13, then a user
        emit(encR(7'h00, 3'b000, 5'd14, 5'd13, 5'd2));
        emit(encS(5'd14, 12'd36));
        expectStore("load use", 32'd36, x[11] + x[2]);
        // Taken branches skip a marker store at 100 and up
        emit(encI(OP_IMM, 3'b000, 5'd15, 5'd1, 12'd0));
        emit(encB(3'b000, 5'd15, 5'd1, 13'd8));        // BEQ taken
        emit(encS(5'd1, 12'd100));
        emit(encI(OP_IMM, 3'b000, 5'd16, 5'd2, 12'd1));
        emit(encB(3'b001, 5'd16, 5'd2, 13'd8));        // BNE taken
        emit(encS(5'd1, 12'd104));
        emit(encI(OP_IMM, 3'b000, 5'd17, 5'd1, 12'd0));
        emit(encB(3'b001, 5'd17, 5'd1, 13'd8));        // BNE not taken
        emit(encS(5'd17, 12'd40));
        expectStore("bne not taken", 32'd40, x[1]);
        emit(encI(OP_IMM, 3'b000, 5'd18, 5'd0, 12'hFFF));
        emit(encB(3'b100, 5'd18, 5'd0, 13'd8));        // BLT taken, -1 < 0
        emit(encS(5'd1, 12'd108));
        emit(encI(OP_IMM, 3'b000, 5'd19, 5'd0, 12'd1));
        emit(encB(3'b100, 5'd19, 5'd0, 13'd8));        // BLT not taken
        emit(encS(5'd19, 12'd44));
        expectStore("blt not taken", 32'd44, 32'd1);
        emit(encI(OP_IMM, 3'b000, 5'd20, 5'd1, 12'd1));
        emit(encB(3'b000, 5'd20, 5'd1, 13'd8));        // BEQ not taken
        emit(encS(5'd20, 12'd48));
        expectStore("beq not taken", 32'd48, x[1] + 32'd1);
        link = 32'(progLen * 4 + 4);
        emit(encJ(5'd21, 21'd8));                      // JAL over a marker
        emit(encS(5'd1, 12'd112));
        emit(encS(5'd21, 12'd52));
        expectStore("jal link", 32'd52, link);
        emit(encI(OP_IMM, 3'b000, 5'd0, 5'd1, 12'd0)); // Write to x0 is dropped
        emit(encS(5'd0, 12'd56));
        expectStore("x0 store", 32'd56, 32'd0);
        emit(encJ(5'd0, 21'd0));                       // Park in a self loop
    endtask

    // Cycle limit, reset checks and store log
    always @(posedge clock) begin
        cycle++;
        assert (cycle < MAX_CYCLES)
        else stopRun("Timeout: the program did not finish its stores in time");
        if (reset && cycle > 1)
            checkValue("reset write enable", 32'd0, {31'd0, memWrEnable});
        if (!reset && !released) begin              // First cycle out of reset
            checkValue("first cycle write enable", 32'd0, {31'd0, memWrEnable});
            checkValue("first fetch address", 32'd0, instAddr);
            released = 1'b1;
        end else if (!reset && memWrEnable) begin
            assert (storeCount < expAddr.size())
            else stopRun("A store appeared after all expected stores");
            checkValue({expName[storeCount], " address"}, expAddr[storeCount], memAddr);
            checkValue(expName[storeCount], expData[storeCount], memWrData);
            ram[memAddr[7:2]] <= memWrData;
            storeCount++;
        end
    end

    initial begin
        reset      = 1'b1;
        storeCount = 0;
        cycle      = 0;
        progLen    = 0;
        released   = 1'b0;
        void'($urandom(13360));
        immA = 12'($urandom);
        immB = 12'($urandom);
        for (int i = 0; i < 64; i++) begin
            rom[i] = encI(OP_IMM, 3'b000, 5'd0, 5'd0, 12'(i));  // NOP tagged with its index
            ram[i] <= 32'h5A000000 + 32'(i);
        end
        loadProgram();
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        wait (storeCount == expData.size());
        repeat (8) @(posedge clock);                // Pipeline drains past the last store
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
